// ==== l2_cache_defines.svh ====
/* Geometry and thread counts of the L2 cache slice.
   Included by the packages and by any module that sizes arrays from them. */
`ifndef L2_CACHE_DEFINES_SVH
`define L2_CACHE_DEFINES_SVH

// Requesting cores and hardware threads per core.
`define L2_NUM_CORES 4
`define L2_NUM_STRANDS 4

// Set associativity and index split of a line address.
`define L2_NUM_WAYS 4
`define L2_SET_INDEX_WIDTH 3
`define L2_NUM_SETS (1 << `L2_SET_INDEX_WIDTH)
`define L2_TAG_WIDTH 23

// Line address excludes the byte offset within the line.
`define L2_ADDR_WIDTH 26
`define L2_LINE_BYTES 64

`endif

// ==== l2_req_pkg.sv ====
/* Request-side types of the L2 slice: operation codes and requester fields.
   Modules name these types in their ports and import the package for the codes. */
`default_nettype none

`include "l2_cache_defines.svh"

package l2_req_pkg;

	// Operation code as carried on the request bus.
	typedef logic [2:0] l2_op_t;

	// Encodings follow the core's PCI opcode map; flush and invalidate are not used here.
	localparam l2_op_t PCI_LOAD = 3'd0;
	localparam l2_op_t PCI_STORE = 3'd1;
	localparam l2_op_t PCI_LOAD_SYNC = 3'd4;
	localparam l2_op_t PCI_STORE_SYNC = 3'd5;

	// Requesting core.
	typedef logic [$clog2(`L2_NUM_CORES)-1:0] l2_unit_t;

	// Hardware thread within the core.
	typedef logic [$clog2(`L2_NUM_STRANDS)-1:0] l2_strand_t;

endpackage

`default_nettype wire

// ==== l2_cache_pkg.sv ====
/* Cache-side types of the L2 slice: position, line, mask and line address.
   Used in the ports of the pipeline stages and the data array. */
`default_nettype none

`include "l2_cache_defines.svh"

package l2_cache_pkg;

	typedef logic [$clog2(`L2_NUM_WAYS)-1:0] l2_way_t;
	typedef logic [`L2_SET_INDEX_WIDTH-1:0] l2_set_t;
	typedef logic [`L2_TAG_WIDTH-1:0] l2_tag_t;

	typedef logic [`L2_LINE_BYTES*8-1:0] l2_line_t;

	// One enable bit per byte of a line.
	typedef logic [`L2_LINE_BYTES-1:0] l2_mask_t;

	// Line address, seen either as one line number or as tag over set.
	typedef union packed {
		logic [`L2_ADDR_WIDTH-1:0] line;
		struct packed {
			l2_tag_t tag;
			l2_set_t set;
		} fields;
	} l2_addr_u;

	// Data array index with the way in the upper bits.
	typedef logic [$bits(l2_way_t)+$bits(l2_set_t)-1:0] l2_index_t;

endpackage

`default_nettype wire

// ==== l2_mask_unit.sv ====
/* Byte merge of two lines under a byte-enable mask.
   Enabled bytes come from data0, the others from data1. */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defines.svh"

module l2_mask_unit(
	input wire l2_cache_pkg::l2_mask_t mask,
	input wire l2_cache_pkg::l2_line_t data0,
	input wire l2_cache_pkg::l2_line_t data1,
	output l2_cache_pkg::l2_line_t result);

	always_comb
	begin
		for (int b = 0; b < `L2_LINE_BYTES; b++)
		begin
			// Mask bit b governs bits 8*b+7 down to 8*b.
			if (mask[b])
				result[b*8 +: 8] = data0[b*8 +: 8];
			else
				result[b*8 +: 8] = data1[b*8 +: 8];
		end
	end

endmodule

`default_nettype wire

// ==== l2_data_array.sv ====
/* Line storage for every way and set of the slice.
   Registered read at the pipeline accept edge, one write port from the write stage. */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defines.svh"

module l2_data_array(
	input wire clk,
	input wire rd_en,
	input wire l2_cache_pkg::l2_index_t rd_index,
	output l2_cache_pkg::l2_line_t rd_data,
	input wire wr_en,
	input wire l2_cache_pkg::l2_index_t wr_index,
	input wire l2_cache_pkg::l2_line_t wr_data);

	import l2_cache_pkg::*;

	localparam int NUM_LINES = `L2_NUM_WAYS * `L2_NUM_SETS;

	l2_line_t lines [NUM_LINES];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			lines[wr_index] <= wr_data;
	end

	// A read and write of the same index return the old line.
	// The read stage patches that case with its bypass.
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= lines[rd_index];
	end

endmodule

`default_nettype wire

// ==== l2_sync_tracker.sv ====
/* Link registers for synchronized load and store, one per core and strand.
   Flags whether the incoming synchronized store succeeds and updates links at accept. */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defines.svh"

module l2_sync_tracker(
	input wire clk,
	input wire rst_n,
	input wire stall_pipeline,
	input wire req_valid,
	input wire l2_req_pkg::l2_unit_t req_unit,
	input wire l2_req_pkg::l2_strand_t req_strand,
	input wire l2_req_pkg::l2_op_t req_op,
	input wire l2_cache_pkg::l2_addr_u req_address,
	output logic sync_success);

	import l2_req_pkg::*;

	localparam int NUM_LINKS = `L2_NUM_CORES * `L2_NUM_STRANDS;

	logic [NUM_LINKS-1:0] link_valid;
	logic [`L2_ADDR_WIDTH-1:0] link_line [NUM_LINKS];
	logic [NUM_LINKS-1:0] line_match;
	logic [$clog2(NUM_LINKS)-1:0] req_id;
	logic accept;

	assign req_id = {req_unit, req_strand};
	assign accept = req_valid && !stall_pipeline;

	// Links currently held on the requested line.
	always_comb
	begin
		for (int i = 0; i < NUM_LINKS; i++)
			line_match[i] = link_valid[i] && link_line[i] == req_address.line;
	end

	assign sync_success = req_valid && req_op == PCI_STORE_SYNC && line_match[req_id];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			link_valid <= '0;
		else if (accept)
		begin
			if (req_op == PCI_LOAD_SYNC)
				link_valid[req_id] <= 1'b1;
			else if (req_op == PCI_STORE || sync_success)
				link_valid <= link_valid & ~line_match;	// Own link included.
			else if (req_op == PCI_STORE_SYNC)
				link_valid[req_id] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && req_op == PCI_LOAD_SYNC)
			link_line[req_id] <= req_address.line;
	end

endmodule

`default_nettype wire

// ==== l2_cache_read.sv ====
/* Read stage of the slice: tag lookup, data array read and the stage register.
   Bypasses same-cycle updates from the write stage and installs restart tags. */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defines.svh"

module l2_cache_read(
	input wire clk,
	input wire rst_n,
	input wire stall_pipeline,
	input wire req_valid,
	input wire l2_req_pkg::l2_unit_t req_unit,
	input wire l2_req_pkg::l2_strand_t req_strand,
	input wire l2_req_pkg::l2_op_t req_op,
	input wire l2_cache_pkg::l2_addr_u req_address,
	input wire l2_cache_pkg::l2_line_t req_data,
	input wire l2_cache_pkg::l2_mask_t req_mask,
	input wire req_has_sm_data,
	input wire l2_cache_pkg::l2_line_t req_sm_data,
	input wire l2_cache_pkg::l2_way_t req_sm_fill_way,
	input wire sync_success,
	output logic rd_valid,
	output l2_req_pkg::l2_unit_t rd_unit,
	output l2_req_pkg::l2_strand_t rd_strand,
	output l2_req_pkg::l2_op_t rd_op,
	output l2_cache_pkg::l2_addr_u rd_address,
	output l2_cache_pkg::l2_line_t rd_data,
	output l2_cache_pkg::l2_mask_t rd_mask,
	output logic rd_has_sm_data,
	output l2_cache_pkg::l2_line_t rd_sm_data,
	output l2_cache_pkg::l2_way_t rd_sm_fill_way,
	output logic rd_cache_hit,
	output l2_cache_pkg::l2_way_t rd_hit_way,
	output logic rd_store_sync_success,
	output l2_cache_pkg::l2_line_t rd_cache_mem_result,
	output logic mem_rd_en,
	output l2_cache_pkg::l2_index_t mem_rd_index,
	input wire l2_cache_pkg::l2_line_t mem_rd_data,
	input wire wr_update_l2_data,
	input wire l2_cache_pkg::l2_index_t wr_cache_write_index,
	input wire l2_cache_pkg::l2_line_t wr_update_data);

	import l2_cache_pkg::*;

	logic [`L2_NUM_WAYS-1:0] tag_valid [`L2_NUM_SETS];
	l2_tag_t tag_mem [`L2_NUM_WAYS][`L2_NUM_SETS];
	logic [`L2_NUM_WAYS-1:0] way_match;
	l2_way_t req_hit_way;
	logic fill_now;
	logic bypass_hit;
	l2_line_t bypass_data;

	// Restart leaving this stage installs its tag at this edge.
	assign fill_now = rd_valid && rd_has_sm_data && !stall_pipeline;

	// Tag compare, with the tag being installed this cycle taking precedence.
	always_comb
	begin
		way_match = '0;
		req_hit_way = '0;
		for (int w = 0; w < `L2_NUM_WAYS; w++)
		begin
			if (fill_now && rd_sm_fill_way == w
				&& rd_address.fields.set == req_address.fields.set)
				way_match[w] = rd_address.fields.tag == req_address.fields.tag;
			else
				way_match[w] = tag_valid[req_address.fields.set][w]
					&& tag_mem[w][req_address.fields.set] == req_address.fields.tag;
			if (way_match[w])
				req_hit_way = l2_way_t'(w);
		end
	end

	assign mem_rd_en = !stall_pipeline;
	assign mem_rd_index = {req_hit_way, req_address.fields.set};

	// The array returns stale data when the write stage hits the same index.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bypass_hit <= 1'b0;
		else if (!stall_pipeline)
			bypass_hit <= wr_update_l2_data && wr_cache_write_index == mem_rd_index;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
			bypass_data <= wr_update_data;
	end

	assign rd_cache_mem_result = bypass_hit ? bypass_data : mem_rd_data;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `L2_NUM_SETS; s++)
				tag_valid[s] <= '0;
		end
		else if (fill_now)
			tag_valid[rd_address.fields.set][rd_sm_fill_way] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill_now)
			tag_mem[rd_sm_fill_way][rd_address.fields.set] <= rd_address.fields.tag;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else if (!stall_pipeline)
			rd_valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			rd_unit <= req_unit;
			rd_strand <= req_strand;
			rd_op <= req_op;
			rd_address <= req_address;
			rd_data <= req_data;
			rd_mask <= req_mask;
			rd_has_sm_data <= req_has_sm_data;
			rd_sm_data <= req_sm_data;
			rd_sm_fill_way <= req_sm_fill_way;
			rd_cache_hit <= |way_match;
			rd_hit_way <= req_hit_way;
			rd_store_sync_success <= sync_success;
		end
	end

endmodule

`default_nettype wire

// ==== l2_cache_write.sv ====
/* Write stage of the slice: merges store bytes into the old line.
   Drives the data array update and registers the response. */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_write(
	input wire clk,
	input wire rst_n,
	input wire stall_pipeline,
	input wire rd_valid,
	input wire l2_req_pkg::l2_unit_t rd_unit,
	input wire l2_req_pkg::l2_strand_t rd_strand,
	input wire l2_req_pkg::l2_op_t rd_op,
	input wire l2_cache_pkg::l2_addr_u rd_address,
	input wire l2_cache_pkg::l2_line_t rd_data,
	input wire l2_cache_pkg::l2_mask_t rd_mask,
	input wire rd_has_sm_data,
	input wire l2_cache_pkg::l2_line_t rd_sm_data,
	input wire l2_cache_pkg::l2_way_t rd_sm_fill_way,
	input wire rd_cache_hit,
	input wire l2_cache_pkg::l2_way_t rd_hit_way,
	input wire rd_store_sync_success,
	input wire l2_cache_pkg::l2_line_t rd_cache_mem_result,
	output logic resp_valid,
	output l2_req_pkg::l2_unit_t resp_unit,
	output l2_req_pkg::l2_strand_t resp_strand,
	output l2_req_pkg::l2_op_t resp_op,
	output l2_cache_pkg::l2_addr_u resp_address,
	output l2_cache_pkg::l2_line_t resp_data,
	output logic resp_cache_hit,
	output logic resp_store_sync_success,
	output logic wr_update_l2_data,
	output l2_cache_pkg::l2_index_t wr_cache_write_index,
	output l2_cache_pkg::l2_line_t wr_update_data);

	import l2_req_pkg::*;
	import l2_cache_pkg::*;

	l2_line_t old_line;
	l2_line_t merged_line;
	logic is_store;
	logic is_store_sync;
	logic store_allowed;

	// A restart supersedes whatever the array returned.
	assign old_line = rd_has_sm_data ? rd_sm_data : rd_cache_mem_result;

	l2_mask_unit mask_unit(
		.mask(rd_mask),
		.data0(rd_data),
		.data1(old_line),
		.result(merged_line));

	assign is_store = rd_op == PCI_STORE;
	assign is_store_sync = rd_op == PCI_STORE_SYNC;
	assign store_allowed = is_store || (is_store_sync && rd_store_sync_success);

	assign wr_cache_write_index = rd_cache_hit
		? {rd_hit_way, rd_address.fields.set}
		: {rd_sm_fill_way, rd_address.fields.set};

	always_comb
	begin
		wr_update_l2_data = 1'b0;
		wr_update_data = merged_line;
		if (rd_valid && !stall_pipeline)
		begin
			if (store_allowed && (rd_cache_hit || rd_has_sm_data))
				wr_update_l2_data = 1'b1;
			else if (rd_has_sm_data)
			begin
				// Loads and failed sync stores still install the fetched line,
				// since the read stage has already claimed the fill way.
				wr_update_l2_data = 1'b1;
				wr_update_data = rd_sm_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else if (!stall_pipeline)
			resp_valid <= rd_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			resp_unit <= rd_unit;
			resp_strand <= rd_strand;
			resp_op <= rd_op;
			resp_address <= rd_address;
			resp_cache_hit <= rd_cache_hit;
			resp_store_sync_success <= rd_store_sync_success;
			if (is_store || is_store_sync)
				resp_data <= merged_line;
			else
				resp_data <= old_line;
		end
	end

endmodule

`default_nettype wire

// ==== l2_cache_slice.sv ====
/* Top of the L2 cache slice pipeline.
   Connects the sync tracker, the read and write stages and the data array. */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_slice(
	input wire clk,
	input wire rst_n,
	input wire stall_pipeline,
	input wire req_valid,
	input wire l2_req_pkg::l2_unit_t req_unit,
	input wire l2_req_pkg::l2_strand_t req_strand,
	input wire l2_req_pkg::l2_op_t req_op,
	input wire l2_cache_pkg::l2_addr_u req_address,
	input wire l2_cache_pkg::l2_line_t req_data,
	input wire l2_cache_pkg::l2_mask_t req_mask,
	input wire req_has_sm_data,
	input wire l2_cache_pkg::l2_line_t req_sm_data,
	input wire l2_cache_pkg::l2_way_t req_sm_fill_way,
	output logic resp_valid,
	output l2_req_pkg::l2_unit_t resp_unit,
	output l2_req_pkg::l2_strand_t resp_strand,
	output l2_req_pkg::l2_op_t resp_op,
	output l2_cache_pkg::l2_addr_u resp_address,
	output l2_cache_pkg::l2_line_t resp_data,
	output logic resp_cache_hit,
	output logic resp_store_sync_success);

	import l2_req_pkg::*;
	import l2_cache_pkg::*;

	logic sync_success;
	logic rd_valid;
	l2_unit_t rd_unit;
	l2_strand_t rd_strand;
	l2_op_t rd_op;
	l2_addr_u rd_address;
	l2_line_t rd_data;
	l2_mask_t rd_mask;
	logic rd_has_sm_data;
	l2_line_t rd_sm_data;
	l2_way_t rd_sm_fill_way;
	logic rd_cache_hit;
	l2_way_t rd_hit_way;
	logic rd_store_sync_success;
	l2_line_t rd_cache_mem_result;
	logic mem_rd_en;
	l2_index_t mem_rd_index;
	l2_line_t mem_rd_data;
	logic wr_update_l2_data;
	l2_index_t wr_cache_write_index;
	l2_line_t wr_update_data;

	l2_sync_tracker tracker(
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.req_valid(req_valid),
		.req_unit(req_unit),
		.req_strand(req_strand),
		.req_op(req_op),
		.req_address(req_address),
		.sync_success(sync_success));

	l2_cache_read read_stage(
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.req_valid(req_valid),
		.req_unit(req_unit),
		.req_strand(req_strand),
		.req_op(req_op),
		.req_address(req_address),
		.req_data(req_data),
		.req_mask(req_mask),
		.req_has_sm_data(req_has_sm_data),
		.req_sm_data(req_sm_data),
		.req_sm_fill_way(req_sm_fill_way),
		.sync_success(sync_success),
		.rd_valid(rd_valid),
		.rd_unit(rd_unit),
		.rd_strand(rd_strand),
		.rd_op(rd_op),
		.rd_address(rd_address),
		.rd_data(rd_data),
		.rd_mask(rd_mask),
		.rd_has_sm_data(rd_has_sm_data),
		.rd_sm_data(rd_sm_data),
		.rd_sm_fill_way(rd_sm_fill_way),
		.rd_cache_hit(rd_cache_hit),
		.rd_hit_way(rd_hit_way),
		.rd_store_sync_success(rd_store_sync_success),
		.rd_cache_mem_result(rd_cache_mem_result),
		.mem_rd_en(mem_rd_en),
		.mem_rd_index(mem_rd_index),
		.mem_rd_data(mem_rd_data),
		.wr_update_l2_data(wr_update_l2_data),
		.wr_cache_write_index(wr_cache_write_index),
		.wr_update_data(wr_update_data));

	l2_cache_write write_stage(
		.clk(clk),
		.rst_n(rst_n),
		.stall_pipeline(stall_pipeline),
		.rd_valid(rd_valid),
		.rd_unit(rd_unit),
		.rd_strand(rd_strand),
		.rd_op(rd_op),
		.rd_address(rd_address),
		.rd_data(rd_data),
		.rd_mask(rd_mask),
		.rd_has_sm_data(rd_has_sm_data),
		.rd_sm_data(rd_sm_data),
		.rd_sm_fill_way(rd_sm_fill_way),
		.rd_cache_hit(rd_cache_hit),
		.rd_hit_way(rd_hit_way),
		.rd_store_sync_success(rd_store_sync_success),
		.rd_cache_mem_result(rd_cache_mem_result),
		.resp_valid(resp_valid),
		.resp_unit(resp_unit),
		.resp_strand(resp_strand),
		.resp_op(resp_op),
		.resp_address(resp_address),
		.resp_data(resp_data),
		.resp_cache_hit(resp_cache_hit),
		.resp_store_sync_success(resp_store_sync_success),
		.wr_update_l2_data(wr_update_l2_data),
		.wr_cache_write_index(wr_cache_write_index),
		.wr_update_data(wr_update_data));

	l2_data_array data_array(
		.clk(clk),
		.rd_en(mem_rd_en),
		.rd_index(mem_rd_index),
		.rd_data(mem_rd_data),
		.wr_en(wr_update_l2_data),
		.wr_index(wr_cache_write_index),
		.wr_data(wr_update_data));

endmodule

`default_nettype wire

// ==== l2_cache_model.svh ====
/* Reference model of the L2 slice: tags, lines, sync links and the two pipeline slots.
   Included in the testbench module body and called once per clock edge. */
`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

typedef struct packed {
	logic valid;
	l2_unit_t unit;
	l2_strand_t strand;
	l2_op_t op;
	l2_addr_u address;
	logic hit;
	logic sync_success;
	logic data_known;
	l2_line_t data;
} expect_t;

localparam int NUM_LINKS = `L2_NUM_CORES * `L2_NUM_STRANDS;

logic model_tag_valid [`L2_NUM_SETS][`L2_NUM_WAYS];
l2_tag_t model_tag [`L2_NUM_SETS][`L2_NUM_WAYS];
l2_line_t model_line [`L2_NUM_SETS][`L2_NUM_WAYS];
logic model_link_valid [NUM_LINKS];
logic [`L2_ADDR_WIDTH-1:0] model_link_line [NUM_LINKS];

// Expected read stage and response registers, plus the outputs seen last cycle.
expect_t in_read;
expect_t in_resp;
expect_t held;
logic edge_stalled;

task automatic reset_model();
	for (int s = 0; s < `L2_NUM_SETS; s++)
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			model_tag_valid[s][w] = 1'b0;
	for (int i = 0; i < NUM_LINKS; i++)
		model_link_valid[i] = 1'b0;
	in_read = '0;
	in_resp = '0;
	held = '0;
	edge_stalled = 1'b0;
endtask

// Returns the resident way of a line, or -1 when absent.
function automatic int find_way(input l2_set_t set, input l2_tag_t tag);
	int way;
	way = -1;
	for (int w = 0; w < `L2_NUM_WAYS; w++)
		if (model_tag_valid[set][w] && model_tag[set][w] == tag)
			way = w;
	return way;
endfunction

function automatic l2_line_t merge_bytes(input l2_mask_t mask, input l2_line_t new_data,
	input l2_line_t old_data);
	l2_line_t result;
	result = old_data;
	for (int b = 0; b < `L2_LINE_BYTES; b++)
		if (mask[b])
			result[b*8 +: 8] = new_data[b*8 +: 8];
	return result;
endfunction

task automatic apply_request(output expect_t e);
	l2_set_t set;
	int way;
	logic [$clog2(NUM_LINKS)-1:0] id;
	logic success;
	l2_line_t old_line;
	l2_line_t merged;
	set = req_address.fields.set;
	way = find_way(set, req_address.fields.tag);
	id = {req_unit, req_strand};
	success = req_op == PCI_STORE_SYNC && model_link_valid[id]
		&& model_link_line[id] == req_address.line;
	if (req_op == PCI_LOAD_SYNC)
	begin
		model_link_valid[id] = 1'b1;
		model_link_line[id] = req_address.line;
	end
	else if (req_op == PCI_STORE || success)
	begin
		for (int i = 0; i < NUM_LINKS; i++)
			if (model_link_line[i] == req_address.line)
				model_link_valid[i] = 1'b0;
	end
	else if (req_op == PCI_STORE_SYNC)
		model_link_valid[id] = 1'b0;
	old_line = '0;
	if (req_has_sm_data)
		old_line = req_sm_data;
	else if (way >= 0)
		old_line = model_line[set][way];
	merged = merge_bytes(req_mask, req_data, old_line);
	// A restart evicts whatever the fill way held.
	if (req_has_sm_data)
	begin
		model_tag_valid[set][req_sm_fill_way] = 1'b1;
		model_tag[set][req_sm_fill_way] = req_address.fields.tag;
		model_line[set][req_sm_fill_way] = (req_op == PCI_STORE || success) ? merged : req_sm_data;
	end
	else if (way >= 0 && (req_op == PCI_STORE || success))
		model_line[set][way] = merged;
	e = '0;
	e.valid = 1'b1;
	e.unit = req_unit;
	e.strand = req_strand;
	e.op = req_op;
	e.address = req_address;
	e.hit = way >= 0;
	e.sync_success = success;
	e.data_known = way >= 0 || req_has_sm_data;
	e.data = (req_op == PCI_STORE || req_op == PCI_STORE_SYNC) ? merged : old_line;
endtask

task automatic advance_model();
	edge_stalled = stall_pipeline;
	if (!stall_pipeline)
	begin
		in_resp = in_read;
		if (req_valid)
			apply_request(in_read);
		else
			in_read = '0;
	end
endtask

task automatic check_outputs();
	if (edge_stalled)
	begin
		assert (resp_valid === held.valid) else report_mismatch("resp_valid", held.valid, resp_valid);
		assert (resp_unit === held.unit) else report_mismatch("resp_unit", held.unit, resp_unit);
		assert (resp_strand === held.strand)
			else report_mismatch("resp_strand", held.strand, resp_strand);
		assert (resp_op === held.op) else report_mismatch("resp_op", held.op, resp_op);
		assert (resp_address === held.address)
			else report_mismatch("resp_address", held.address, resp_address);
		assert (resp_data === held.data) else report_mismatch("resp_data", held.data, resp_data);
		assert (resp_cache_hit === held.hit)
			else report_mismatch("resp_cache_hit", held.hit, resp_cache_hit);
		assert (resp_store_sync_success === held.sync_success) else report_mismatch(
			"resp_store_sync_success", held.sync_success, resp_store_sync_success);
	end
	assert (resp_valid === in_resp.valid)
		else report_mismatch("resp_valid", in_resp.valid, resp_valid);
	if (in_resp.valid)
	begin
		assert (resp_unit === in_resp.unit) else report_mismatch("resp_unit", in_resp.unit, resp_unit);
		assert (resp_strand === in_resp.strand)
			else report_mismatch("resp_strand", in_resp.strand, resp_strand);
		assert (resp_op === in_resp.op) else report_mismatch("resp_op", in_resp.op, resp_op);
		assert (resp_address === in_resp.address)
			else report_mismatch("resp_address", in_resp.address, resp_address);
		assert (resp_cache_hit === in_resp.hit)
			else report_mismatch("resp_cache_hit", in_resp.hit, resp_cache_hit);
		assert (resp_store_sync_success === in_resp.sync_success) else report_mismatch(
			"resp_store_sync_success", in_resp.sync_success, resp_store_sync_success);
		// A plain miss returns whatever way 0 of the set held.
		if (in_resp.data_known)
			assert (resp_data === in_resp.data)
				else report_mismatch("resp_data", in_resp.data, resp_data);
	end
	held.valid = resp_valid;
	held.unit = resp_unit;
	held.strand = resp_strand;
	held.op = resp_op;
	held.address = resp_address;
	held.data = resp_data;
	held.hit = resp_cache_hit;
	held.sync_success = resp_store_sync_success;
endtask

`endif

// ==== l2_cache_slice_tb.sv ====
/* Randomized testbench for the L2 cache slice.
   Drives LFSR requests, restarts and stalls, and checks every response against an included model. */
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_defines.svh"

module l2_cache_slice_tb;

	import l2_req_pkg::*;
	import l2_cache_pkg::*;

	localparam logic [31:0] SEED = 32'hf32c_8a9e;
	localparam int NUM_CYCLES = 2000;
	localparam int RESET_CYCLES = 4;
	localparam int DRAIN_CYCLES = 4;
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;

	// Address pool of two sets times six tags.
	localparam l2_set_t SET_LOW = 3'd2;
	localparam l2_set_t SET_HIGH = 3'd5;
	localparam l2_tag_t TAG_BASE = 23'h35_a1c0;
	localparam l2_tag_t TAG_STRIDE = 23'h01_0911;
	localparam l2_op_t OPS [4] = '{PCI_LOAD, PCI_STORE, PCI_LOAD_SYNC, PCI_STORE_SYNC};

	logic clk;
	logic rst_n;
	logic stall_pipeline;
	logic req_valid;
	l2_unit_t req_unit;
	l2_strand_t req_strand;
	l2_op_t req_op;
	l2_addr_u req_address;
	l2_line_t req_data;
	l2_mask_t req_mask;
	logic req_has_sm_data;
	l2_line_t req_sm_data;
	l2_way_t req_sm_fill_way;
	logic resp_valid;
	l2_unit_t resp_unit;
	l2_strand_t resp_strand;
	l2_op_t resp_op;
	l2_addr_u resp_address;
	l2_line_t resp_data;
	logic resp_cache_hit;
	logic resp_store_sync_success;
	logic [31:0] lfsr_state;
	int cycle_count = 0;

	`include "l2_cache_model.svh"

	l2_cache_slice uut(.*);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	// Taps 32, 22, 2 and 1.
	function automatic logic next_lfsr_bit();
		logic feedback;
		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [511:0] random_bits(input int count);
		logic [511:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[510:0], next_lfsr_bit()};
		return value;
	endfunction

	task automatic report_mismatch(input string name, input logic [511:0] expected,
		input logic [511:0] actual);
		$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic drive_idle();
		stall_pipeline = 1'b0;
		req_valid = 1'b0;
		req_unit = '0;
		req_strand = '0;
		req_op = PCI_LOAD;
		req_address = '0;
		req_data = '0;
		req_mask = '0;
		req_has_sm_data = 1'b0;
		req_sm_data = '0;
		req_sm_fill_way = '0;
	endtask

	task automatic drive_request();
		logic [2:0] tag_sel;
		stall_pipeline = 3'(random_bits(3)) == 3'd0;
		req_valid = 2'(random_bits(2)) != 2'd0;
		req_unit = l2_unit_t'(random_bits(2));
		req_strand = l2_strand_t'(random_bits(2));
		req_op = OPS[2'(random_bits(2))];
		tag_sel = 3'(random_bits(3) % 6);
		req_address.fields.set = 1'(random_bits(1)) ? SET_HIGH : SET_LOW;
		req_address.fields.tag = TAG_BASE + l2_tag_t'(tag_sel) * TAG_STRIDE;
		req_data = random_bits(512);
		req_mask = l2_mask_t'(random_bits(64));
		req_has_sm_data = 1'b0;
		req_sm_data = '0;
		req_sm_fill_way = '0;
		// Restarts only bring in lines that are not resident.
		if (find_way(req_address.fields.set, req_address.fields.tag) < 0 && 1'(random_bits(1)))
		begin
			req_has_sm_data = 1'b1;
			req_sm_data = random_bits(512);
			req_sm_fill_way = l2_way_t'(random_bits(2));
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		lfsr_state = SEED;
		drive_idle();
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int cycle = 0; cycle < NUM_CYCLES + DRAIN_CYCLES; cycle++)
		begin
			@(posedge clk);
			advance_model();
			#1;
			check_outputs();
			if (cycle < NUM_CYCLES)
				drive_request();
			else
				drive_idle();
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
l2_req_pkg.sv
l2_cache_pkg.sv
l2_mask_unit.sv
l2_data_array.sv
l2_sync_tracker.sv
l2_cache_read.sv
l2_cache_write.sv
l2_cache_slice.sv
l2_cache_slice_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the L2 slice testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module l2_cache_slice_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vl2_cache_slice_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
